// File: tb.f
verilog/cpu_pkg.sv
verilog/pipe_if.sv
verilog/register_file.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/riscv_core.sv
sim/store_checker.sv
sim/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_top -f tb.f -Mdir obj_dir -o tb_sim \
    || { echo "Build failed"; exit 1; }
./obj_dir/tb_sim 2>&1 | tee sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
    || grep -q "TESTBENCH PASSED" sim.log \
    || { echo "Simulation ended without a result"; exit 1; }
exit 0

// File: sim/tb_top.sv
`timescale 1ns/100ps

module tb_top import cpu_pkg::*; ();
    localparam int N_PROGS    = 4;
    localparam int BODY       = 120;
    localparam int DUMP_BASE  = 'h300;
    localparam int TIMEOUT_NS = N_PROGS * 3 * 256 * 4 + 2000;

    logic       clk;
    logic       rst_n;
    word_t      instr;
    word_t      mem_rdata;
    word_t      pc;
    word_t      mem_addr;
    word_t      mem_wdata;
    logic       mem_we;
    logic       mem_re;
    logic       fill_req;
    logic       prog_load;
    logic       prog_end;
    logic [7:0] prog_idx;
    int         error_count;
    int         store_count;
    word_t      rom [256];
    word_t      ram [256];
    logic [31:0] rng;
    word_t      end_pc;

    riscv_core #(.RESET_PC('0)) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .mem_rdata (mem_rdata),
        .pc        (pc),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_re    (mem_re)
    );

    store_checker chk (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_we      (mem_we),
        .mem_re      (mem_re),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .prog_load   (prog_load),
        .prog_end    (prog_end),
        .rom         (rom),
        .ram_img     (ram),
        .error_count (error_count),
        .store_count (store_count)
    );

    // Same-cycle memories
    assign instr     = rom[pc[9:2]];
    assign mem_rdata = ram[mem_addr[9:2]];

    always @(posedge clk) begin
        if (fill_req) begin
            for (int i = 0; i < 256; i++)
                ram[i] <= {prog_idx, 8'(i), ~8'(i), 8'hc3};
        end else if (mem_we) begin
            ram[mem_addr[9:2]] <= mem_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    function automatic int pick(int n);
        return int'(next_rand() % n);
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // Clear, random body, register dump, self-loop
    task automatic build_program();
        int          idx;
        int          k;
        int          slot;
        int          body_end;
        logic [63:0] written;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        word_t       r;
        idx = 0;
        written = '0;
        body_end = 31 + BODY;
        for (int i = 0; i < 256; i++)
            rom[i] = 32'h0000_006f;
        for (int i = 1; i < 32; i++) begin
            rom[idx] = enc_i(12'h0, 5'd0, 3'b000, 5'(i), 7'b0010011);
            idx++;
        end
        while (idx < body_end) begin
            rd  = 5'(pick(8));   // Small register set for dense dependencies
            rs1 = 5'(pick(8));
            rs2 = 5'(pick(8));
            r   = next_rand();
            case (pick(10))
                0: rom[idx] = {r[19:0], rd, 7'b0110111};
                1, 2: rom[idx] = enc_i(r[11:0], rs1, 3'b000, rd, 7'b0010011);
                3, 4, 5: begin
                    f7 = 7'h00;
                    case (pick(8))
                        0: f3 = 3'b000;
                        1: begin
                            f3 = 3'b000;
                            f7 = 7'h20;
                        end
                        2: f3 = 3'b111;
                        3: f3 = 3'b110;
                        4: f3 = 3'b100;
                        5: f3 = 3'b010;
                        6: f3 = 3'b001;
                        default: f3 = 3'b101;
                    endcase
                    rom[idx] = enc_r(f7, rs2, rs1, f3, rd);
                end
                6: begin
                    slot = pick(64);
                    written[slot] = 1'b1;
                    rom[idx] = enc_s(12'(slot * 4), rs2, 5'd0);
                end
                7: begin
                    if (written != '0 && idx + 1 < body_end) begin
                        do
                            slot = pick(64);
                        while (!written[slot]);
                        rom[idx] = enc_i(12'(slot * 4), 5'd0, 3'b010, rd, 7'b0000011);
                        idx++;
                        rom[idx] = enc_r(7'h00, rs2, rd, 3'b000, 5'(pick(8)));   // Load-use
                    end else begin
                        rom[idx] = enc_i(r[11:0], rs1, 3'b000, rd, 7'b0010011);
                    end
                end
                8: begin
                    k = 1 + pick(4);
                    if (idx + k <= body_end)
                        rom[idx] = enc_b(13'(k * 4), rs2, rs1, (pick(2) != 0) ? 3'b001 : 3'b000);
                    else
                        rom[idx] = enc_i(r[11:0], rs1, 3'b000, rd, 7'b0010011);
                end
                default: begin
                    k = 1 + pick(4);
                    if (idx + k <= body_end)
                        rom[idx] = enc_j(21'(k * 4), rd);
                    else
                        rom[idx] = enc_i(r[11:0], rs1, 3'b000, rd, 7'b0010011);
                end
            endcase
            idx++;
        end
        for (int i = 1; i < 32; i++) begin
            rom[idx] = enc_s(12'(DUMP_BASE + 4 * (i - 1)), 5'(i), 5'd0);
            idx++;
        end
        end_pc = word_t'(idx * 4);
    endtask

    initial begin
        rst_n     = 1'b0;
        fill_req  = 1'b0;
        prog_load = 1'b0;
        prog_end  = 1'b0;
        prog_idx  = '0;
        rng       = 32'h639a;
        end_pc    = '0;
        for (int p = 0; p < N_PROGS; p++) begin
            @(posedge clk);
            rst_n    <= 1'b0;
            prog_idx <= 8'(p);
            build_program();
            fill_req <= 1'b1;
            @(posedge clk);
            fill_req  <= 1'b0;
            prog_load <= 1'b1;
            @(posedge clk);
            prog_load <= 1'b0;
            repeat (3) @(posedge clk);
            rst_n <= 1'b1;
            do
                @(negedge clk);
            while (pc != end_pc);
            repeat (6) @(posedge clk);   // Drain the dump stores
            prog_end <= 1'b1;
            @(posedge clk);
            prog_end <= 1'b0;
        end
        @(posedge clk);
        $display("Checks finished: %0d errors, %0d stores compared", error_count, store_count);
        if (error_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired: the core never reached the end of a program");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: sim/store_checker.sv
`timescale 1ns/100ps

module store_checker import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  mem_we,
    input  logic  mem_re,
    input  word_t mem_addr,
    input  word_t mem_wdata,
    input  logic  prog_load,
    input  logic  prog_end,
    input  word_t rom [256],
    input  word_t ram_img [256],
    output int    error_count,
    output int    store_count
);
    // 31 clearing ADDIs plus the pipeline depth
    localparam int FIRST_MEM_CYCLE = 35;

    word_t exp_addr [$];
    word_t exp_data [$];
    word_t exp_load [$];
    int    errors = 0;
    int    stores = 0;
    int    cyc = 0;

    assign error_count = errors;
    assign store_count = stores;

    // Sequential ISA model of one program image
    function automatic void ref_run();
        word_t     x [32];
        word_t     mem [256];
        word_t     pc;
        word_t     pc_next;
        word_t     ins;
        word_t     a;
        word_t     b;
        word_t     ad;
        word_t     res;
        word_t     imm_i;
        word_t     imm_s;
        word_t     imm_b;
        word_t     imm_j;
        reg_addr_t rd;
        logic [2:0] f3;
        logic      wr;
        int        steps;
        exp_addr.delete();
        exp_data.delete();
        exp_load.delete();
        for (int i = 0; i < 32; i++)
            x[i] = '0;
        for (int i = 0; i < 256; i++)
            mem[i] = ram_img[i];
        pc = '0;
        steps = 0;
        while (steps < 1000) begin
            ins = rom[pc[9:2]];
            if (ins == 32'h0000_006f)   // Self-loop marks the end
                break;
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            rd    = ins[11:7];
            f3    = ins[14:12];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            wr      = 1'b0;
            res     = '0;
            pc_next = pc + 32'd4;
            case (ins[6:0])
                7'b0110111: begin
                    res = {ins[31:12], 12'b0};
                    wr  = 1'b1;
                end
                7'b1101111: begin
                    res     = pc + 32'd4;
                    wr      = 1'b1;
                    pc_next = pc + imm_j;
                end
                7'b1100011: begin
                    if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b))
                        pc_next = pc + imm_b;
                end
                7'b0000011: begin
                    if (f3 == 3'b010) begin
                        ad  = a + imm_i;
                        res = mem[ad[9:2]];
                        wr  = 1'b1;
                        exp_load.push_back(ad);
                    end
                end
                7'b0100011: begin
                    if (f3 == 3'b010) begin
                        ad = a + imm_s;
                        mem[ad[9:2]] = b;
                        exp_addr.push_back(ad);
                        exp_data.push_back(b);
                    end
                end
                7'b0010011: begin
                    if (f3 == 3'b000) begin
                        res = a + imm_i;
                        wr  = 1'b1;
                    end
                end
                7'b0110011: begin
                    wr = 1'b1;
                    case ({ins[31:25], f3})
                        {7'h00, 3'b000}: res = a + b;
                        {7'h20, 3'b000}: res = a - b;
                        {7'h00, 3'b111}: res = a & b;
                        {7'h00, 3'b110}: res = a | b;
                        {7'h00, 3'b100}: res = a ^ b;
                        {7'h00, 3'b010}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        {7'h00, 3'b001}: res = a << b[4:0];
                        {7'h00, 3'b101}: res = a >> b[4:0];
                        default:         wr = 1'b0;
                    endcase
                end
                default: ;
            endcase
            if (wr && rd != 5'd0)
                x[rd] = res;
            pc = pc_next;
            steps++;
        end
    endfunction

    always @(negedge clk) begin
        if (!rst_n) begin
            cyc = 0;
            if (mem_we !== 1'b0 || mem_re !== 1'b0) begin
                $display("Memory strobe not low during reset at time %0t", $time);
                errors++;
            end
            if (prog_load)
                ref_run();
        end else begin
            cyc++;
            if ((mem_we || mem_re) && cyc < FIRST_MEM_CYCLE) begin
                $display("Memory strobe raised at time %0t before any memory instruction",
                         $time);
                errors++;
            end
            if (mem_re) begin
                if (exp_load.size() == 0) begin
                    $display("Extra load at time %0t from %h", $time, mem_addr);
                    errors++;
                end else begin
                    if (mem_addr !== exp_load[0]) begin
                        $display("FAILED time=%0t signal=mem_addr expected=%h actual=%h",
                                 $time, exp_load[0], mem_addr);
                        errors++;
                    end
                    void'(exp_load.pop_front());
                end
            end
            if (mem_we) begin
                stores++;
                if (exp_addr.size() == 0) begin
                    $display("Extra store at time %0t to %h with data %h",
                             $time, mem_addr, mem_wdata);
                    errors++;
                end else begin
                    if (mem_addr !== exp_addr[0]) begin
                        $display("FAILED time=%0t signal=mem_addr expected=%h actual=%h",
                                 $time, exp_addr[0], mem_addr);
                        errors++;
                    end
                    if (mem_wdata !== exp_data[0]) begin
                        $display("FAILED time=%0t signal=mem_wdata expected=%h actual=%h",
                                 $time, exp_data[0], mem_wdata);
                        errors++;
                    end
                    void'(exp_addr.pop_front());
                    void'(exp_data.pop_front());
                end
            end
            if (prog_end && exp_addr.size() != 0) begin
                $display("Missing stores: %0d expected stores never appeared by time %0t",
                         exp_addr.size(), $time);
                errors++;
                exp_addr.delete();
                exp_data.delete();
            end
            if (prog_end && exp_load.size() != 0) begin
                $display("Missing loads: %0d expected loads never appeared by time %0t",
                         exp_load.size(), $time);
                errors++;
                exp_load.delete();
            end
        end
    end

endmodule

// File: verilog/riscv_core.sv
`timescale 1ns/100ps

module riscv_core import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst_n,
    input  word_t instr,
    input  word_t mem_rdata,
    output word_t pc,
    output word_t mem_addr,
    output word_t mem_wdata,
    output logic  mem_we,
    output logic  mem_re
);
    word_t     if_instr;
    word_t     if_pc;
    logic      if_valid;
    logic      stall;
    logic      redirect;
    word_t     redirect_pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_val;
    word_t     rs2_val;
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_value;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc),
        .if_instr    (if_instr),
        .if_pc       (if_pc),
        .if_valid    (if_valid)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_instr (if_instr),
        .if_pc    (if_pc),
        .if_valid (if_valid),
        .redirect (redirect),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .stall    (stall),
        .id_ex    (id_ex.producer)
    );

    register_file u_regs (
        .clk      (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_value (wb_value),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_we       (wb_we),
        .wb_rd       (wb_rd),
        .wb_value    (wb_value),
        .id_ex       (id_ex.consumer),
        .ex_mem      (ex_mem.producer),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    mem_wb_stage u_mem_wb (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .ex_mem    (ex_mem.consumer),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .wb_we     (wb_we),
        .wb_rd     (wb_rd),
        .wb_value  (wb_value)
    );

endmodule

// File: verilog/mem_wb_stage.sv
`timescale 1ns/100ps

module mem_wb_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     mem_rdata,
    ex_mem_if.consumer ex_mem,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    output logic      mem_we,
    output logic      mem_re,
    output logic      wb_we,
    output reg_addr_t wb_rd,
    output word_t     wb_value
);
    logic wb_we_q;

    assign mem_addr  = ex_mem.result;
    assign mem_wdata = ex_mem.store_data;
    assign mem_we    = ex_mem.valid && ex_mem.mem_we;   // One cycle per access
    assign mem_re    = ex_mem.valid && ex_mem.mem_re;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb_we_q <= 1'b0;
        else
            wb_we_q <= ex_mem.valid && ex_mem.rd_we;
    end

    always_ff @(posedge clk) begin
        wb_rd    <= ex_mem.rd_addr;
        wb_value <= ex_mem.mem_re ? mem_rdata : ex_mem.result;
    end

    assign wb_we = wb_we_q && wb_rd != '0;   // Never write x0

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/100ps

module execute_stage import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wb_we,
    input  reg_addr_t  wb_rd,
    input  word_t      wb_value,
    id_ex_if.consumer  id_ex,
    ex_mem_if.producer ex_mem,
    output logic       redirect,
    output word_t      redirect_pc
);
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    word_t    op_a;
    word_t    op_b_reg;
    word_t    op_b;
    word_t    alu_out;
    word_t    result;
    logic     taken;

    // Memory stage is younger, so it has priority
    function automatic fwd_sel_t fwd_pick(reg_addr_t rs);
        fwd_sel_t sel;
        sel = FWD_REG;
        if (rs != '0) begin
            if (ex_mem.valid && ex_mem.rd_we && ex_mem.rd_addr == rs)
                sel = FWD_MEM;
            else if (wb_we && wb_rd == rs)
                sel = FWD_WB;
        end
        return sel;
    endfunction

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val);
        case (sel)
            FWD_MEM: return ex_mem.result;
            FWD_WB:  return wb_value;
            default: return reg_val;
        endcase
    endfunction

    assign fwd_a    = fwd_pick(id_ex.rs1_addr);
    assign fwd_b    = fwd_pick(id_ex.rs2_addr);
    assign op_a     = fwd_mux(fwd_a, id_ex.rs1_val);
    assign op_b_reg = fwd_mux(fwd_b, id_ex.rs2_val);
    assign op_b     = id_ex.use_imm ? id_ex.imm : op_b_reg;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    assign result = (id_ex.opcode == OPC_JAL) ? id_ex.pc + 32'd4 : alu_out;   // Link value

    // funct3 bit 0 turns BEQ into BNE
    assign taken       = (op_a == op_b_reg) ^ id_ex.funct3_lsb;
    assign redirect    = id_ex.valid &&
                         (id_ex.opcode == OPC_JAL || (id_ex.opcode == OPC_BRANCH && taken));
    assign redirect_pc = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem.valid  <= 1'b0;
            ex_mem.rd_we  <= 1'b0;
            ex_mem.mem_re <= 1'b0;
            ex_mem.mem_we <= 1'b0;
        end else begin
            ex_mem.valid  <= id_ex.valid;
            ex_mem.rd_we  <= id_ex.rd_we;
            ex_mem.mem_re <= id_ex.mem_re;
            ex_mem.mem_we <= id_ex.mem_we;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.rd_addr    <= id_ex.rd_addr;
        ex_mem.result     <= result;
        ex_mem.store_data <= op_b_reg;
    end

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/100ps

module decode_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     if_instr,
    input  word_t     if_pc,
    input  logic      if_valid,
    input  logic      redirect,
    input  word_t     rs1_val,
    input  word_t     rs2_val,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output logic      stall,
    id_ex_if.producer id_ex
);
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm;
    opcode_t    dec_opc;
    alu_op_t    dec_alu;
    logic       legal;
    logic       rd_we;
    logic       use_imm;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       is_load;
    logic       is_store;

    assign rs1_addr = if_instr[19:15];
    assign rs2_addr = if_instr[24:20];
    assign funct3   = if_instr[14:12];
    assign funct7   = if_instr[31:25];

    always_comb begin
        legal    = 1'b0;
        dec_opc  = OPC_IMM;
        dec_alu  = ALU_ADD;
        imm      = {{20{if_instr[31]}}, if_instr[31:20]};   // I-type
        rd_we    = 1'b0;
        use_imm  = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        case (if_instr[6:0])
            OPC_LUI: begin
                legal   = 1'b1;
                dec_opc = OPC_LUI;
                dec_alu = ALU_PASS_B;
                imm     = {if_instr[31:12], 12'b0};
                rd_we   = 1'b1;
                use_imm = 1'b1;
            end
            OPC_JAL: begin
                legal   = 1'b1;
                dec_opc = OPC_JAL;
                imm     = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
                           if_instr[30:21], 1'b0};
                rd_we   = 1'b1;
            end
            OPC_BRANCH: begin
                legal    = (funct3 == 3'b000) || (funct3 == 3'b001);
                dec_opc  = OPC_BRANCH;
                dec_alu  = ALU_SUB;
                imm      = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
                            if_instr[11:8], 1'b0};
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OPC_LOAD: begin
                legal    = (funct3 == 3'b010);   // LW only
                dec_opc  = OPC_LOAD;
                rd_we    = 1'b1;
                use_imm  = 1'b1;
                uses_rs1 = 1'b1;
                is_load  = 1'b1;
            end
            OPC_STORE: begin
                legal    = (funct3 == 3'b010);
                dec_opc  = OPC_STORE;
                imm      = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
                use_imm  = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                is_store = 1'b1;
            end
            OPC_IMM: begin
                legal    = (funct3 == 3'b000);   // ADDI
                rd_we    = 1'b1;
                use_imm  = 1'b1;
                uses_rs1 = 1'b1;
            end
            OPC_REG: begin
                legal    = 1'b1;
                dec_opc  = OPC_REG;
                rd_we    = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec_alu = ALU_ADD;
                    {7'h20, 3'b000}: dec_alu = ALU_SUB;
                    {7'h00, 3'b111}: dec_alu = ALU_AND;
                    {7'h00, 3'b110}: dec_alu = ALU_OR;
                    {7'h00, 3'b100}: dec_alu = ALU_XOR;
                    {7'h00, 3'b010}: dec_alu = ALU_SLT;
                    {7'h00, 3'b001}: dec_alu = ALU_SLL;
                    {7'h00, 3'b101}: dec_alu = ALU_SRL;
                    default:         legal   = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    // Load sitting in execute feeds a source of this instruction
    assign stall = if_valid && id_ex.valid && id_ex.mem_re && id_ex.rd_addr != '0 &&
                   ((uses_rs1 && id_ex.rd_addr == rs1_addr) ||
                    (uses_rs2 && id_ex.rd_addr == rs2_addr));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex.valid  <= 1'b0;
            id_ex.rd_we  <= 1'b0;
            id_ex.mem_re <= 1'b0;
            id_ex.mem_we <= 1'b0;
        end else if (redirect || stall) begin   // Bubble
            id_ex.valid  <= 1'b0;
            id_ex.rd_we  <= 1'b0;
            id_ex.mem_re <= 1'b0;
            id_ex.mem_we <= 1'b0;
        end else begin
            id_ex.valid  <= if_valid && legal;
            id_ex.rd_we  <= rd_we;
            id_ex.mem_re <= is_load;
            id_ex.mem_we <= is_store;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.pc         <= if_pc;
        id_ex.rs1_addr   <= rs1_addr;
        id_ex.rs2_addr   <= rs2_addr;
        id_ex.rs1_val    <= rs1_val;
        id_ex.rs2_val    <= rs2_val;
        id_ex.imm        <= imm;
        id_ex.rd_addr    <= if_instr[11:7];
        id_ex.alu_op     <= dec_alu;
        id_ex.opcode     <= dec_opc;
        id_ex.funct3_lsb <= funct3[0];
        id_ex.use_imm    <= use_imm;
    end

endmodule

// File: verilog/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst_n,
    input  word_t instr,
    input  logic  stall,
    input  logic  redirect,
    input  word_t redirect_pc,
    output word_t pc,
    output word_t if_instr,
    output word_t if_pc,
    output logic  if_valid
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= RESET_PC;
        else if (redirect)        // Redirect wins over stall
            pc <= redirect_pc;
        else if (!stall)
            pc <= pc + 32'd4;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            if_valid <= 1'b0;
        else if (redirect)
            if_valid <= 1'b0;
        else if (!stall)
            if_valid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (redirect) begin
            if_instr <= NOP_INSTR;
        end else if (!stall) begin
            if_instr <= instr;
            if_pc    <= pc;
        end
    end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/100ps

module register_file import cpu_pkg::*; (
    input  logic      clk,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  logic      wb_we,
    input  reg_addr_t wb_rd,
    input  word_t     wb_value,
    output word_t     rs1_val,
    output word_t     rs2_val
);
    word_t regs [1:31];   // x0 is not stored

    always_ff @(posedge clk) begin
        if (wb_we && wb_rd != '0)
            regs[wb_rd] <= wb_value;
    end

    // Write in the same cycle is seen by the read
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0)
            return '0;
        if (wb_we && wb_rd == addr)
            return wb_value;
        return regs[addr];
    endfunction

    assign rs1_val = read_port(rs1_addr);
    assign rs2_val = read_port(rs2_addr);

endmodule

// File: verilog/pipe_if.sv
`timescale 1ns/100ps

interface id_ex_if import cpu_pkg::*; ();
    logic      valid;
    word_t     pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    reg_addr_t rd_addr;
    logic      rd_we;
    alu_op_t   alu_op;
    opcode_t   opcode;
    logic      funct3_lsb;   // BNE when set
    logic      use_imm;
    logic      mem_re;
    logic      mem_we;

    modport producer (output valid, pc, rs1_addr, rs2_addr, rs1_val, rs2_val, imm, rd_addr,
                      rd_we, alu_op, opcode, funct3_lsb, use_imm, mem_re, mem_we);
    modport consumer (input valid, pc, rs1_addr, rs2_addr, rs1_val, rs2_val, imm, rd_addr,
                      rd_we, alu_op, opcode, funct3_lsb, use_imm, mem_re, mem_we);
endinterface

interface ex_mem_if import cpu_pkg::*; ();
    logic      valid;
    reg_addr_t rd_addr;
    logic      rd_we;
    word_t     result;       // ALU result, also the memory address
    word_t     store_data;
    logic      mem_re;
    logic      mem_we;

    modport producer (output valid, rd_addr, rd_we, result, store_data, mem_re, mem_we);
    modport consumer (input valid, rd_addr, rd_we, result, store_data, mem_re, mem_we);
endinterface

// File: verilog/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_IMM    = 7'b0010011,
        OPC_REG    = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B   // LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    localparam word_t NOP_INSTR = 32'h0000_0013;   // addi x0, x0, 0

endpackage
